// File: list.f
design/icache_pkg.sv
design/icache_lookup_if.sv
design/icache_tag_store.sv
design/icache_data_store.sv
design/icache_refill_ctrl.sv
design/icache_top.sv
testbench/icache_checker.sv
testbench/icache_tb.sv

// File: Makefile
# Verilator build and run for the instruction cache testbench

VERILATOR    ?= verilator
TOP          ?= icache_tb
FILELIST     ?= list.f
BUILD_DIR    ?= obj_dir
LOG          ?= sim.log
FAIL_PATTERN ?= TEST FAILED
PASS_PATTERN ?= TEST PASSED
VFLAGS       ?= --binary --timing

SOURCES := $(shell cat $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_PATTERN)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "$(PASS_PATTERN)" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;

    localparam int test_count  = 42;
    localparam int sweep_start = 10;

    logic        clk           = 1'b0;
    logic        rst           = 1'b1;
    logic [31:0] cpu_req_addr  = '0;
    logic        cpu_req_valid = 1'b0;
    logic [31:0] cpu_req_data;
    logic        cpu_req_ready;
    logic        flush         = 1'b0;
    logic [31:0] mem_req_data  = '0;
    logic        mem_req_ready = 1'b0;
    logic [31:0] mem_req_addr;
    logic        mem_req_valid;

    int          error_count;
    int          pass_count;

    string       names   [test_count];
    logic [31:0] addrs   [test_count];
    logic        flushes [test_count]; // Flush is raised together with the request
    logic        misses  [test_count];

    logic [31:0] lfsr     = 32'h0000_3466;
    logic [2:0]  delay_bits;
    int          bit_idx;
    logic        mem_busy = 1'b0;
    logic [3:0]  mem_wait = '0;

    always #4 clk = ~clk;

    icache_top UUT (
        .clk           (clk),
        .rst           (rst),
        .cpu_req_addr  (cpu_req_addr),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req_data  (cpu_req_data),
        .cpu_req_ready (cpu_req_ready),
        .flush         (flush),
        .mem_req_data  (mem_req_data),
        .mem_req_ready (mem_req_ready),
        .mem_req_addr  (mem_req_addr),
        .mem_req_valid (mem_req_valid)
    );

    icache_checker u_checker (
        .clk           (clk),
        .rst           (rst),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req_data  (cpu_req_data),
        .cpu_req_ready (cpu_req_ready),
        .flush         (flush),
        .mem_req_addr  (mem_req_addr),
        .mem_req_valid (mem_req_valid),
        .error_count   (error_count),
        .pass_count    (pass_count)
    );

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic add_test(input int n, input string name, input logic [31:0] addr,
                            input logic with_flush, input logic miss);
        names[n]   = name;
        addrs[n]   = addr;
        flushes[n] = with_flush;
        misses[n]  = miss;
    endtask

    task automatic load_table();
        int k;
        add_test(0, "cold_a",     32'h0000_1234, 1'b0, 1'b1);
        add_test(1, "hit_a",      32'h0000_1234, 1'b0, 1'b0);
        add_test(2, "cold_b",     32'hABCD_0567, 1'b0, 1'b1);
        add_test(3, "hit_b_upper", 32'h1111_0567, 1'b0, 1'b0); // Upper half differs
        add_test(4, "conflict_c", 32'h0000_2224, 1'b0, 1'b1);  // Same index as cold_a
        add_test(5, "hit_c",      32'h0000_2224, 1'b0, 1'b0);
        add_test(6, "evicted_a",  32'h0000_1234, 1'b0, 1'b1);
        add_test(7, "hit_a2",     32'h0000_1234, 1'b0, 1'b0);
        add_test(8, "flushed_a",  32'h0000_1234, 1'b1, 1'b1);
        add_test(9, "hit_a3",     32'h0000_1234, 1'b0, 1'b0);
        // Sweep gives line k the tag 0xC00 + k
        for (k = 0; k < 16; k++)
        begin
            add_test(sweep_start + k, $sformatf("sweep_miss_%0d", k),
                     32'h0000_C000 + 32'(k * 17), k == 0, 1'b1);
            add_test(sweep_start + 16 + k, $sformatf("sweep_hit_%0d", k),
                     32'h0000_C000 + 32'(k * 17), 1'b0, 1'b0);
        end
    endtask

    // Memory answers once per request after 1 to 8 cycles
    always @(posedge clk)
    begin
        if (rst)
        begin
            mem_req_ready <= 1'b0;
            mem_busy      <= 1'b0;
        end
        else if (mem_req_ready)
        begin
            mem_req_ready <= 1'b0;
        end
        else if (mem_busy)
        begin
            if (mem_wait == 4'd1)
            begin
                mem_req_ready <= 1'b1;
                mem_req_data  <= mem_req_addr ^ 32'h5A5A_0000;
                mem_busy      <= 1'b0;
            end
            else
            begin
                mem_wait <= mem_wait - 4'd1;
            end
        end
        else if (mem_req_valid)
        begin
            for (bit_idx = 0; bit_idx < 3; bit_idx++)
            begin
                lfsr       = lfsr_step(lfsr);
                delay_bits = {delay_bits[1:0], lfsr[0]};
            end
            mem_wait <= {1'b0, delay_bits} + 4'd1;
            mem_busy <= 1'b1;
        end
    end

    initial
    begin
        int i;
        load_table();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        for (i = 0; i < test_count; i++)
        begin
            u_checker.begin_test(names[i], addrs[i], misses[i]);
            cpu_req_valid <= 1'b1;
            cpu_req_addr  <= addrs[i];
            flush         <= flushes[i];
            @(posedge clk);
            flush <= 1'b0;
            while (!cpu_req_ready)
                @(posedge clk);
            cpu_req_valid <= 1'b0;
            @(posedge clk); // One idle edge between requests
        end
        @(posedge clk);
        $display("Tests: %0d run, %0d passed, %0d errors", test_count, pass_count, error_count);
        if (error_count == 0 && pass_count == test_count)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        repeat (test_count * 20) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", test_count * 20);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: testbench/icache_checker.sv
`timescale 1ns/1ps

module icache_checker (
    input  logic        clk,
    input  logic        rst,
    input  logic        cpu_req_valid,
    input  logic [31:0] cpu_req_data,
    input  logic        cpu_req_ready,
    input  logic        flush,
    input  logic [31:0] mem_req_addr,
    input  logic        mem_req_valid,
    output int          error_count,
    output int          pass_count
);

    string       exp_name;
    logic [31:0] exp_addr;
    logic        exp_miss;
    int          start_count;   // Bumped by the stimulus loop for each new test
    int          seen_count;
    logic        active;
    logic        captured;
    logic        test_ok;
    int          cycle;
    int          capture_cycle;
    int          mem_reqs;
    logic        prev_mem_valid;

    // Memory answers with the word address XOR a fixed pattern
    function automatic logic [31:0] refill_word(input logic [31:0] addr);
        return {16'h0000, addr[15:0]} ^ 32'h5A5A_0000;
    endfunction

    task automatic begin_test(input string name, input logic [31:0] addr, input logic miss);
        exp_name    = name;
        exp_addr    = addr;
        exp_miss    = miss;
        start_count = start_count + 1;
    endtask

    task automatic note_failure(input string line);
        $display("%s", line);
        error_count = error_count + 1;
        test_ok     = 1'b0;
    endtask

    task automatic finish_test();
        int exp_reqs;
        exp_reqs = exp_miss ? 1 : 0;
        if (!captured)
            note_failure($sformatf("%s finished before its request was accepted", exp_name));
        if (mem_reqs != exp_reqs)
            note_failure($sformatf("Fail %s expected %0d memory requests got %0d",
                                   exp_name, exp_reqs, mem_reqs));
        if (cpu_req_data !== refill_word(exp_addr))
            note_failure($sformatf("Fail %s expected %h got %h",
                                   exp_name, refill_word(exp_addr), cpu_req_data));
        if (!exp_miss && captured && (cycle - capture_cycle != 2))
            note_failure($sformatf("Fail %s expected hit latency 2 got %0d",
                                   exp_name, cycle - capture_cycle));
        if (test_ok)
        begin
            $display("Pass %s", exp_name);
            pass_count = pass_count + 1;
        end
        active = 1'b0;
    endtask

    // All inputs are read as they stood just before the edge
    always @(posedge clk)
    begin
        cycle = cycle + 1;
        if (rst)
        begin
            active         = 1'b0;
            prev_mem_valid = 1'b0;
            error_count    = 0;
            pass_count     = 0;
        end
        else
        begin
            if (start_count != seen_count)
            begin
                seen_count = start_count;
                active     = 1'b1;
                captured   = 1'b0;
                test_ok    = 1'b1;
                mem_reqs   = 0;
            end
            // An idle cache takes the request on the first edge without flush
            if (active && !captured && cpu_req_valid && !flush)
            begin
                captured      = 1'b1;
                capture_cycle = cycle;
            end
            if (mem_req_valid && !prev_mem_valid)
            begin
                mem_reqs = mem_reqs + 1;
                if (!active)
                    note_failure("Memory request seen with no CPU request outstanding");
                else if (mem_req_addr !== {16'h0000, exp_addr[15:0]})
                    note_failure($sformatf("Fail %s expected mem addr %h got %h",
                                           exp_name, {16'h0000, exp_addr[15:0]}, mem_req_addr));
            end
            prev_mem_valid = mem_req_valid;
            if (cpu_req_ready)
            begin
                if (!active)
                    note_failure("cpu_req_ready pulsed with no request outstanding");
                else
                    finish_test();
            end
        end
    end

endmodule

// File: design/icache_top.sv
`timescale 1ns/1ps

module icache_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [31:0]                       cpu_req_addr,
    input  logic                              cpu_req_valid,
    output logic [icache_pkg::word_width-1:0] cpu_req_data,
    output logic                              cpu_req_ready,
    input  logic                              flush,
    input  logic [icache_pkg::word_width-1:0] mem_req_data,
    input  logic                              mem_req_ready,
    output logic [31:0]                       mem_req_addr,
    output logic                              mem_req_valid
);
    import icache_pkg::*;

    logic                   dstore_wr_en;
    logic [index_width-1:0] dstore_index;
    logic [word_width-1:0]  dstore_wr_data;
    logic [word_width-1:0]  dstore_rd_data;

    icache_lookup_if lookup ();

    icache_tag_store u_tag_store (
        .clk    (clk),
        .rst    (rst),
        .lookup (lookup.tag_store)
    );

    icache_data_store u_data_store (
        .clk     (clk),
        .wr_en   (dstore_wr_en),
        .index   (dstore_index),
        .wr_data (dstore_wr_data),
        .rd_data (dstore_rd_data)
    );

    icache_refill_ctrl u_refill_ctrl (
        .clk           (clk),
        .rst           (rst),
        .cpu_req_addr  (cpu_req_addr),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req_data  (cpu_req_data),
        .cpu_req_ready (cpu_req_ready),
        .flush         (flush),
        .mem_req_data  (mem_req_data),
        .mem_req_ready (mem_req_ready),
        .mem_req_addr  (mem_req_addr),
        .mem_req_valid (mem_req_valid),
        .lookup        (lookup.ctrl),
        .wr_en         (dstore_wr_en),
        .index         (dstore_index),
        .wr_data       (dstore_wr_data),
        .rd_data       (dstore_rd_data)
    );

endmodule

// File: design/icache_refill_ctrl.sv
`timescale 1ns/1ps

module icache_refill_ctrl (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [31:0]                        cpu_req_addr,
    input  logic                               cpu_req_valid,
    output logic [icache_pkg::word_width-1:0]  cpu_req_data,
    output logic                               cpu_req_ready,
    input  logic                               flush,
    input  logic [icache_pkg::word_width-1:0]  mem_req_data,
    input  logic                               mem_req_ready,
    output logic [31:0]                        mem_req_addr,
    output logic                               mem_req_valid,
    icache_lookup_if.ctrl                      lookup,
    output logic                               wr_en,
    output logic [icache_pkg::index_width-1:0] index,
    output logic [icache_pkg::word_width-1:0]  wr_data,
    input  logic [icache_pkg::word_width-1:0]  rd_data
);
    import icache_pkg::*;

    refill_state_t         state;
    refill_state_t         state_next;
    logic [addr_width-1:0] addr_q;
    logic                  fill;
    logic                  flush_take;

    // Flush is only taken while idle and then holds off a new request for a cycle
    assign flush_take = (state == st_idle) && flush;
    assign fill       = (state == st_allocate) && mem_req_ready;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= st_idle;
        end
        else
        begin
            state <= state_next;
        end
    end

    always_comb
    begin
        state_next = state;
        case (state)
            st_idle:
            begin
                if (cpu_req_valid && !flush)
                begin
                    state_next = st_compare;
                end
            end
            st_compare:
            begin
                if (lookup.hit)
                begin
                    state_next = st_respond;
                end
                else
                begin
                    state_next = st_allocate;
                end
            end
            st_allocate:
            begin
                if (mem_req_ready)
                begin
                    state_next = st_compare; // Arrays are written on this edge
                end
            end
            st_respond: state_next = st_idle;
            default:    state_next = st_idle;
        endcase
    end

    // The CPU holds its address until ready, so sampling every idle cycle is safe
    always_ff @(posedge clk)
    begin
        if (state == st_idle)
        begin
            addr_q <= cpu_req_addr[addr_width-1:0];
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == st_compare && lookup.hit)
        begin
            cpu_req_data <= rd_data;
        end
    end

    assign cpu_req_ready = (state == st_respond);

    assign mem_req_valid = (state == st_allocate);
    assign mem_req_addr  = {{(32 - addr_width){1'b0}}, addr_q};

    assign lookup.index   = addr_q[index_width-1:0];
    assign lookup.tag     = addr_q[addr_width-1:index_width];
    assign lookup.fill_en = fill;
    assign lookup.flush   = flush_take;

    assign wr_en   = fill;
    assign index   = addr_q[index_width-1:0];
    assign wr_data = mem_req_data;

endmodule

// File: design/icache_data_store.sv
`timescale 1ns/1ps

module icache_data_store (
    input  logic                              clk,
    input  logic                              wr_en,
    input  logic [icache_pkg::index_width-1:0] index,
    input  logic [icache_pkg::word_width-1:0]  wr_data,
    output logic [icache_pkg::word_width-1:0]  rd_data
);
    import icache_pkg::*;

    logic [word_width-1:0] mem [line_count];

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[index] <= wr_data; // Refill word from memory
        end
    end

    // Read is asynchronous so the controller can register it in st_compare
    assign rd_data = mem[index];

endmodule

// File: design/icache_tag_store.sv
`timescale 1ns/1ps

module icache_tag_store (
    input  logic               clk,
    input  logic               rst,
    icache_lookup_if.tag_store lookup
);
    import icache_pkg::*;

    logic [line_count-1:0] valid;
    logic [tag_width-1:0]  tags [line_count];

    // Reset or flush clears every valid bit
    always_ff @(posedge clk)
    begin
        if (rst || lookup.flush)
        begin
            valid <= '0;
        end
        else if (lookup.fill_en)
        begin
            valid[lookup.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (lookup.fill_en)
        begin
            tags[lookup.index] <= lookup.tag;
        end
    end

    assign lookup.hit = valid[lookup.index] && (tags[lookup.index] == lookup.tag);

endmodule

// File: design/icache_lookup_if.sv
`timescale 1ns/1ps

interface icache_lookup_if;
    import icache_pkg::*;

    logic [index_width-1:0] index;
    logic [tag_width-1:0]   tag;
    logic                   hit;     // Indexed line is valid and its tag matches
    logic                   fill_en;
    logic                   flush;

    modport tag_store (
        input  index,
        input  tag,
        input  fill_en,
        input  flush,
        output hit
    );

    modport ctrl (
        output index,
        output tag,
        output fill_en,
        output flush,
        input  hit
    );

endinterface

// File: design/icache_pkg.sv
package icache_pkg;

    // Line select and tag split of the 16-bit word address
    localparam int index_width = 4;
    localparam int tag_width   = 12;
    localparam int addr_width  = index_width + tag_width;

    localparam int line_count  = 16;
    localparam int word_width  = 32;

    // Controller states, in the order a miss walks through them
    typedef enum logic [1:0] {
        st_idle,     // Waits for a request or a flush
        st_compare,  // Tag lookup on the captured address
        st_allocate, // Memory read outstanding
        st_respond   // Data and ready presented to the CPU
    } refill_state_t;

endpackage
